// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/exePkg.sv
      - logic/mulDivIf.sv
      - logic/alu.sv
      - logic/mulDivCtrl.sv
      - logic/iterCounter.sv
      - logic/mulDivDatapath.sv
      - logic/exeStage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/exeStage_properties.sv
      - tests/exeStageTb.sv

// ==== list.f ====
+incdir+logic
logic/exePkg.sv
logic/mulDivIf.sv
logic/alu.sv
logic/mulDivCtrl.sv
logic/iterCounter.sv
logic/mulDivDatapath.sv
logic/exeStage.sv
tests/exeStage_properties.sv
tests/exeStageTb.sv

// ==== logic/alu.sv ====
//////////////////////////////////////////////////////////////////////
// combinational integer ALU
// add/sub, logic ops, shifts, set-less-than, overflow flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module alu (
    input  logic [`EXE_DATA_WIDTH-1:0] srcA,
    input  logic [`EXE_DATA_WIDTH-1:0] srcB,
    input  logic [4:0]                 aluOp,
    input  exePkg::ExceptinPipeType    exceptIn,
    output logic [`EXE_DATA_WIDTH-1:0] aluOut,
    output exePkg::ExceptinPipeType    exceptOut
);

    logic addOvf;
    logic subOvf;

    always_comb begin
        unique case (aluOp)
            // add and subtract wrap, overflow handled below
            `EXE_ALUOp_ADD, `EXE_ALUOp_ADDU: aluOut = srcA + srcB;
            `EXE_ALUOp_SUB, `EXE_ALUOp_SUBU: aluOut = srcA - srcB;
            // covers OR and ORI
            `EXE_ALUOp_ORI: aluOut = srcA | srcB;
            `EXE_ALUOp_NOR: aluOut = ~(srcA | srcB);
            // shift amount always comes in on srcA[4:0]
            `EXE_ALUOp_SLL, `EXE_ALUOp_SLLV: aluOut = srcB << srcA[4:0];
            `EXE_ALUOp_SRL, `EXE_ALUOp_SRLV: aluOut = srcB >> srcA[4:0];
            `EXE_ALUOp_SRA, `EXE_ALUOp_SRAV: aluOut = $signed(srcB) >>> srcA[4:0];
            `EXE_ALUOp_SLT: begin
                aluOut = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            end
            `EXE_ALUOp_SLTU: begin
                aluOut = (srcA < srcB) ? 32'd1 : 32'd0;
            end
            `EXE_ALUOp_XOR: aluOut = srcA ^ srcB;
            `EXE_ALUOp_AND: aluOut = srcA & srcB;
            // unknown code
            default: aluOut = '0;
        endcase
    end

    // add overflows when both operands share a sign the sum lacks
    assign addOvf = (~srcA[31] & ~srcB[31] & aluOut[31]) |
                    (srcA[31] & srcB[31] & ~aluOut[31]);

    // sub overflows when signs differ and result flips from srcA
    assign subOvf = (~srcA[31] & srcB[31] & aluOut[31]) |
                    (srcA[31] & ~srcB[31] & ~aluOut[31]);

    always_comb begin
        // upstream flags pass straight through
        exceptOut = exceptIn;
        // trapping forms only, the U variants never flag
        exceptOut.Overflow = ((aluOp == `EXE_ALUOp_ADD) & addOvf) |
                             ((aluOp == `EXE_ALUOp_SUB) & subOvf);
    end

endmodule

// ==== logic/exePkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared execute stage types
// pipeline exception record, multiply/divide operation select
//////////////////////////////////////////////////////////////////////
package exePkg;

    // exception flags carried down the pipeline
    // one bit per cause, overflow is the only one raised here
    typedef struct packed {
        logic Interrupt;
        logic WrongAddressinIF;
        logic ReservedInstruction;
        logic Syscall;
        logic Break;
        logic Eret;
        logic WrWrongAddressinMEM;
        logic RdWrongAddressinMEM;
        logic Overflow;
    } ExceptinPipeType;

    // multiply/divide unit operations
    // signed forms use magnitudes plus a sign fix at the end
    typedef enum logic [1:0] {
        MD_MULT  = 2'd0,
        MD_MULTU = 2'd1,
        MD_DIV   = 2'd2,
        MD_DIVU  = 2'd3
    } mulDivOpType;

endpackage

// ==== logic/exeStage.sv ====
//////////////////////////////////////////////////////////////////////
// execute stage top level
// ALU path plus iterative multiply/divide unit with HI/LO
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`EXE_DATA_WIDTH-1:0] srcA,
    input  logic [`EXE_DATA_WIDTH-1:0] srcB,
    input  logic [4:0]                 aluOp,
    input  exePkg::ExceptinPipeType    exceptIn,
    output logic [`EXE_DATA_WIDTH-1:0] aluOut,
    output exePkg::ExceptinPipeType    exceptOut,
    input  logic                       mdStart,
    input  exePkg::mulDivOpType        mdOp,
    output logic                       mdBusy,
    output logic                       mdDone,
    output logic [`EXE_DATA_WIDTH-1:0] hi,
    output logic [`EXE_DATA_WIDTH-1:0] lo
);

    // strobes shared by the multiply/divide blocks
    mulDivIf mdBus ();

    // zero-latency integer path
    alu uAlu (
        .srcA      (srcA),
        .srcB      (srcB),
        .aluOp     (aluOp),
        .exceptIn  (exceptIn),
        .aluOut    (aluOut),
        .exceptOut (exceptOut)
    );

    // sequencing, only accepts a start when fully idle
    mulDivCtrl uMdCtrl (
        .clk     (clk),
        .rstN    (rstN),
        .mdStart (mdStart),
        .mdBusy  (mdBusy),
        .mdDone  (mdDone),
        .md      (mdBus.ctrl)
    );

    // 32 step cycles per operation
    iterCounter uIterCnt (
        .clk  (clk),
        .rstN (rstN),
        .md   (mdBus.counter)
    );

    // operands shared with the ALU ports
    mulDivDatapath uMdPath (
        .clk  (clk),
        .rstN (rstN),
        .srcA (srcA),
        .srcB (srcB),
        .mdOp (mdOp),
        .md   (mdBus.datapath),
        .hi   (hi),
        .lo   (lo)
    );

endmodule

// ==== logic/exe_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// execute stage configuration macros
// data width, ALU operation codes, multiply/divide iteration count
//////////////////////////////////////////////////////////////////////
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// operand and result width
`define EXE_DATA_WIDTH 32

// ALU operation codes, 5 bit
// code 0 and anything above 16 give a zero result
`define EXE_ALUOp_ADD  5'd1
`define EXE_ALUOp_ADDU 5'd2
`define EXE_ALUOp_SUB  5'd3
`define EXE_ALUOp_SUBU 5'd4
`define EXE_ALUOp_ORI  5'd5
`define EXE_ALUOp_NOR  5'd6
`define EXE_ALUOp_SLL  5'd7
`define EXE_ALUOp_SLLV 5'd8
`define EXE_ALUOp_SRL  5'd9
`define EXE_ALUOp_SRLV 5'd10
`define EXE_ALUOp_SRA  5'd11
`define EXE_ALUOp_SRAV 5'd12
`define EXE_ALUOp_SLT  5'd13
`define EXE_ALUOp_SLTU 5'd14
`define EXE_ALUOp_XOR  5'd15
`define EXE_ALUOp_AND  5'd16

// shift/add or shift/subtract passes per multiply/divide
`define EXE_MD_ITER 32

`endif

// ==== logic/iterCounter.sv ====
//////////////////////////////////////////////////////////////////////
// iteration down counter for the multiply/divide unit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module iterCounter (
    input  logic      clk,
    input  logic      rstN,
    mulDivIf.counter  md
);

    logic [4:0] count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (md.load) begin
            // preset so that the final step sees zero
            count <= 5'(`EXE_MD_ITER - 1);
        end else if (md.step) begin
            count <= count - 5'd1;
        end
    end

    // high during the last of the step cycles
    assign md.last = (count == 5'd0);

endmodule

// ==== logic/mulDivCtrl.sv ====
//////////////////////////////////////////////////////////////////////
// multiply/divide sequencing FSM
// load, iterate and sign-fix phases, busy and done outputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mulDivCtrl (
    input  logic   clk,
    input  logic   rstN,
    input  logic   mdStart,
    output logic   mdBusy,
    output logic   mdDone,
    mulDivIf.ctrl  md
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2,
        FIX  = 2'd3
    } stateType;

    stateType state;
    stateType stateNext;
    logic     busyQ;
    logic     doneQ;

    always_comb begin
        stateNext = state;
        unique case (state)
            // busyQ still high in the done cycle, so wait it out
            IDLE: if (mdStart && !busyQ) stateNext = LOAD;
            LOAD: stateNext = RUN;
            // leave after the step that counter marks as last
            RUN:  if (md.step && md.last) stateNext = FIX;
            FIX:  stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            busyQ <= 1'b0;
            doneQ <= 1'b0;
        end else begin
            state <= stateNext;
            // busy lags the state by one cycle
            busyQ <= (state != IDLE);
            // done follows fix, HI/LO written on the same edge
            doneQ <= (state == FIX);
        end
    end

    // strobes decoded straight from state
    assign md.load = (state == LOAD);
    assign md.step = (state == RUN);
    assign md.fix  = (state == FIX);

    assign mdBusy = busyQ;
    assign mdDone = doneQ;

endmodule

// ==== logic/mulDivDatapath.sv ====
//////////////////////////////////////////////////////////////////////
// multiply/divide datapath
// operand magnitudes, shift-add multiply, restoring divide,
// sign fix and the HI/LO registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module mulDivDatapath (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`EXE_DATA_WIDTH-1:0] srcA,
    input  logic [`EXE_DATA_WIDTH-1:0] srcB,
    input  exePkg::mulDivOpType        mdOp,
    mulDivIf.datapath                  md,
    output logic [`EXE_DATA_WIDTH-1:0] hi,
    output logic [`EXE_DATA_WIDTH-1:0] lo
);

    // operands sampled with the start pulse
    logic [`EXE_DATA_WIDTH-1:0]   aReg;
    logic [`EXE_DATA_WIDTH-1:0]   bReg;
    exePkg::mulDivOpType          opReg;
    logic                         isSigned;
    logic                         signA;
    logic                         signB;
    logic [`EXE_DATA_WIDTH-1:0]   aMag;
    logic [`EXE_DATA_WIDTH-1:0]   bMagNext;
    // working register, {partial, multiplier} or {remainder, quotient}
    logic [2*`EXE_DATA_WIDTH-1:0] acc;
    logic [`EXE_DATA_WIDTH-1:0]   bMag;
    logic                         isDiv;
    logic                         negQuo;
    logic                         negRem;
    logic [`EXE_DATA_WIDTH:0]     mulSum;
    logic [`EXE_DATA_WIDTH:0]     divRem;
    logic [`EXE_DATA_WIDTH:0]     divDiff;
    logic                         divFits;
    logic [2*`EXE_DATA_WIDTH-1:0] prodFixed;

    // mdStart cycle operands are held through the load cycle
    always_ff @(posedge clk) begin
        aReg  <= srcA;
        bReg  <= srcB;
        opReg <= mdOp;
    end

    assign isSigned = (opReg == exePkg::MD_MULT) || (opReg == exePkg::MD_DIV);
    assign signA    = isSigned & aReg[31];
    assign signB    = isSigned & bReg[31];
    // most negative value maps onto itself, still right as unsigned
    assign aMag     = signA ? -aReg : aReg;
    assign bMagNext = signB ? -bReg : bReg;

    // multiply, add multiplicand into upper half when lsb set
    assign mulSum = {1'b0, acc[2*`EXE_DATA_WIDTH-1:`EXE_DATA_WIDTH]} +
                    (acc[0] ? {1'b0, bMag} : '0);

    // divide, shift in next dividend bit and trial subtract
    assign divRem  = acc[2*`EXE_DATA_WIDTH-1:`EXE_DATA_WIDTH-1];
    assign divFits = (divRem >= {1'b0, bMag});
    assign divDiff = divRem - {1'b0, bMag};

    always_ff @(posedge clk) begin
        if (md.load) begin
            acc    <= {{`EXE_DATA_WIDTH{1'b0}}, aMag};
            bMag   <= bMagNext;
            isDiv  <= (opReg == exePkg::MD_DIV) || (opReg == exePkg::MD_DIVU);
            // product and quotient share the same sign rule
            negQuo <= signA ^ signB;
            // remainder follows the dividend
            negRem <= signA;
        end else if (md.step) begin
            if (isDiv) begin
                // zero divisor always fits, all ones quotient
                acc <= {divFits ? divDiff[`EXE_DATA_WIDTH-1:0] : divRem[`EXE_DATA_WIDTH-1:0],
                        acc[`EXE_DATA_WIDTH-2:0], divFits};
            end else begin
                acc <= {mulSum, acc[`EXE_DATA_WIDTH-1:1]};
            end
        end
    end

    // whole 64-bit product negated as one value
    assign prodFixed = negQuo ? -acc : acc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (md.fix) begin
            if (isDiv) begin
                // quotient to LO, remainder to HI
                lo <= negQuo ? -acc[`EXE_DATA_WIDTH-1:0] : acc[`EXE_DATA_WIDTH-1:0];
                hi <= negRem ? -acc[2*`EXE_DATA_WIDTH-1:`EXE_DATA_WIDTH]
                             : acc[2*`EXE_DATA_WIDTH-1:`EXE_DATA_WIDTH];
            end else begin
                hi <= prodFixed[2*`EXE_DATA_WIDTH-1:`EXE_DATA_WIDTH];
                lo <= prodFixed[`EXE_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== logic/mulDivIf.sv ====
//////////////////////////////////////////////////////////////////////
// multiply/divide control interface
// strobes between FSM, iteration counter and datapath
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface mulDivIf;

    // one cycle, capture operands and operation
    logic load;
    // one cycle per iteration
    logic step;
    // one cycle, sign fix and HI/LO write
    logic fix;
    // counter sits on its final iteration
    logic last;

    modport ctrl (output load, output step, output fix, input last);

    modport counter (input load, input step, output last);

    modport datapath (input load, input step, input fix);

endinterface

// ==== tests/exeStageTb.sv ====
//////////////////////////////////////////////////////////////////////
// execute stage testbench with random ALU and multiply/divide traffic
// checked against a behavioral model, watchdog and closing report
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exeStageTb;

    // alu ops, multiplies, divides, ignored-start runs
    localparam int NumTrans = 400 + 60 + 60 + 4;

    logic clk;
    logic rstN;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [4:0] aluOp;
    exePkg::ExceptinPipeType exceptIn;
    logic [31:0] aluOut;
    exePkg::ExceptinPipeType exceptOut;
    logic mdStart;
    exePkg::mulDivOpType mdOp;
    logic mdBusy;
    logic mdDone;
    logic [31:0] hi;
    logic [31:0] lo;
    integer seed;
    int errors;

    exeStage UUT (.*);

    always #20 clk = ~clk;

    // mixes in zero, all ones, most negative, shift amounts 0 and 31
    function automatic logic [31:0] cornerMix(input logic [31:0] r, input logic [2:0] sel);
        case (sel)
            3'd0: return 32'h0000_0000;
            3'd1: return 32'hffff_ffff;
            3'd2: return 32'h8000_0000;
            3'd3: return {r[31:5], 5'd31};
            3'd4: return {r[31:5], 5'd0};
            default: return r;
        endcase
    endfunction

    function automatic logic [31:0] aluModel(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            `EXE_ALUOp_ADD, `EXE_ALUOp_ADDU: return a + b;
            `EXE_ALUOp_SUB, `EXE_ALUOp_SUBU: return a - b;
            `EXE_ALUOp_ORI: return a | b;
            `EXE_ALUOp_NOR: return ~(a | b);
            `EXE_ALUOp_SLL, `EXE_ALUOp_SLLV: return b << a[4:0];
            `EXE_ALUOp_SRL, `EXE_ALUOp_SRLV: return b >> a[4:0];
            // sign-extend to 64 bits and shift logically
            `EXE_ALUOp_SRA, `EXE_ALUOp_SRAV: return 32'({{32{b[31]}}, b} >> a[4:0]);
            // flipping the sign bits turns signed order into unsigned order
            `EXE_ALUOp_SLT: return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            `EXE_ALUOp_SLTU: return {31'd0, a < b};
            `EXE_ALUOp_XOR: return a ^ b;
            `EXE_ALUOp_AND: return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // signed overflow from operand signs against the wrapped result
    function automatic logic ovfModel(input logic [4:0] op, input logic [31:0] a, b);
        logic [31:0] s;
        logic [31:0] d;
        s = a + b;
        d = a - b;
        if (op == `EXE_ALUOp_ADD) return (a[31] == b[31]) && (s[31] != a[31]);
        if (op == `EXE_ALUOp_SUB) return (a[31] != b[31]) && (d[31] != a[31]);
        return 1'b0;
    endfunction

    // returns {hi, lo}
    function automatic logic [63:0] mdModel(input exePkg::mulDivOpType op, input logic [31:0] a, b);
        logic sgn;
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] q;
        logic [31:0] r;
        sgn = (op == exePkg::MD_MULT) || (op == exePkg::MD_DIV);
        if (op == exePkg::MD_MULT) return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        if (op == exePkg::MD_MULTU) return {32'd0, a} * {32'd0, b};
        am = (sgn && a[31]) ? -a : a;
        bm = (sgn && b[31]) ? -b : b;
        q = (bm == 0) ? 32'hffff_ffff : am / bm;
        r = (bm == 0) ? am : am % bm;
        // quotient negated when the signs differ
        if (sgn && (a[31] ^ b[31])) q = -q;
        // remainder follows the dividend
        if (sgn && a[31]) r = -r;
        return {r, q};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic aluRun();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0] op;
        exePkg::ExceptinPipeType ex;
        exePkg::ExceptinPipeType expEx;
        a = cornerMix($random(seed), 3'($random(seed)));
        b = cornerMix($random(seed), 3'($random(seed)));
        // codes 0 and 17 exercise the zero default
        op = 5'({$random(seed)} % 18);
        ex = exePkg::ExceptinPipeType'($random(seed));
        @(posedge clk);
        srcA <= a;
        srcB <= b;
        aluOp <= op;
        exceptIn <= ex;
        @(negedge clk);
        expEx = ex;
        expEx.Overflow = ovfModel(op, a, b);
        checkValue("aluOut", aluOut, aluModel(op, a, b));
        checkValue("exceptOut", exceptOut, expEx);
    endtask

    // start pulse then wait for done
    // dup sends a second start mid-run
    task automatic mdRun(input exePkg::mulDivOpType op, input logic [31:0] a, b, input bit dup);
        logic [63:0] exp;
        int cycles;
        int extra;
        exp = mdModel(op, a, b);
        @(posedge clk);
        mdStart <= 1'b1;
        mdOp <= op;
        srcA <= a;
        srcB <= b;
        // edge 0 samples the start
        @(posedge clk);
        mdStart <= 1'b0;
        @(negedge clk);
        cycles = 0;
        // busy only rises at edge 1
        checkValue("mdBusy", mdBusy, 0);
        while (!mdDone && cycles < 40) begin
            @(posedge clk);
            mdStart <= dup && (cycles == 9);
            // operands only valid in the start cycle
            srcA <= $random(seed);
            srcB <= $random(seed);
            @(negedge clk);
            cycles++;
            // busy from edge 1 through the done cycle
            checkValue("mdBusy", mdBusy, 1);
        end
        checkValue("mdDone latency", cycles, 34);
        checkValue("hi", hi, exp[63:32]);
        checkValue("lo", lo, exp[31:0]);
        if (dup) begin
            extra = 0;
            repeat (40) begin
                @(negedge clk);
                if (mdDone) extra++;
            end
            assert (extra == 0) else begin
                errors++;
                $display("second mdDone seen after a start issued while busy");
            end
        end
    endtask

    // watchdog
    initial begin
        #(NumTrans * 40 * 40);
        $display("timeout: watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        srcA = '0;
        srcB = '0;
        aluOp = '0;
        exceptIn = '0;
        mdStart = 1'b0;
        mdOp = exePkg::MD_MULT;
        seed = 53;
        errors = 0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("mdBusy", mdBusy, 0);
        checkValue("mdDone", mdDone, 0);
        checkValue("hi", hi, 0);
        checkValue("lo", lo, 0);
        repeat (400) aluRun();
        // multiplies then divides
        // zero divisors come from the corner mix
        repeat (60) mdRun(exePkg::mulDivOpType'({1'b0, 1'($random(seed))}),
            cornerMix($random(seed), 3'($random(seed))),
            cornerMix($random(seed), 3'($random(seed))), 1'b0);
        repeat (60) mdRun(exePkg::mulDivOpType'({1'b1, 1'($random(seed))}),
            cornerMix($random(seed), 3'($random(seed))),
            cornerMix($random(seed), 3'($random(seed))), 1'b0);
        repeat (4) mdRun(exePkg::mulDivOpType'(2'($random(seed))), $random(seed),
            $random(seed), 1'b1);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/exeStage_properties.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the multiply/divide handshake
// and on the ALU overflow flag, bound into exeStage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exeStage_properties (
    input logic                    clk,
    input logic                    rstN,
    input logic                    mdBusy,
    input logic                    mdDone,
    input logic [4:0]              aluOp,
    input exePkg::ExceptinPipeType exceptOut
);

    // done is a single-cycle pulse
    doneOnePulse: assert property (@(posedge clk) disable iff (!rstN) mdDone |=> !mdDone)
        else $error("mdDone held high for more than one cycle");

    // busy still high in the done cycle
    doneInsideBusy: assert property (@(posedge clk) disable iff (!rstN) mdDone |-> mdBusy)
        else $error("mdDone high while mdBusy low");

    // unit comes out of reset idle
    idleAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !mdBusy)
        else $error("mdBusy high in the cycle after reset");

    // only the trapping add and subtract may flag
    ovfOnlyAddSub: assert property (@(posedge clk) disable iff (!rstN)
        exceptOut.Overflow |-> (aluOp == `EXE_ALUOp_ADD || aluOp == `EXE_ALUOp_SUB))
        else $error("Overflow set for an operation other than ADD or SUB");

endmodule

bind exeStage exeStage_properties props (.*);
